// ==== decode_unit.sv ====
`timescale 1ns/1ns
`include "riscv_macros.svh"

module decode_unit (
    input  riscv_pkg::fetch_pkt_t   i_fetch,
    output logic [`REG_ADDR_W-1:0]  o_rs1,
    output logic [`REG_ADDR_W-1:0]  o_rs2,
    input  logic [`XLEN-1:0]        i_rs1_data,
    input  logic [`XLEN-1:0]        i_rs2_data,
    output riscv_pkg::dec_pkt_t     o_dec
);
    import riscv_pkg::*;

    logic [`XLEN-1:0] inst;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    op_e              op;
    logic [`XLEN-1:0] imm;

    assign inst   = i_fetch.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign o_rs1  = inst[19:15];
    assign o_rs2  = inst[24:20];

    always_comb begin
        op = NOP; // anything unknown
        case (opcode)
            7'b0110111: op = LUI;
            7'b0010111: op = AUIPC;
            7'b1101111: op = JAL;
            7'b1100111: if (funct3 == 3'b000) op = JALR;
            7'b0100011: if (funct3 == 3'b000) op = SB;
            7'b1100011: begin
                case (funct3)
                    3'b000:  op = BEQ;
                    3'b001:  op = BNE;
                    3'b100:  op = BLT;
                    3'b101:  op = BGE;
                    3'b110:  op = BLTU;
                    3'b111:  op = BGEU;
                    default: op = NOP;
                endcase
            end
            7'b0010011: begin
                case (funct3)
                    3'b000:  op = ADDI;
                    3'b010:  op = SLTI;
                    3'b011:  op = SLTIU;
                    3'b100:  op = XORI;
                    3'b110:  op = ORI;
                    3'b111:  op = ANDI;
                    3'b001:  if (funct7 == 7'h00) op = SLLI;
                    default: begin
                        if (funct7 == 7'h00) op = SRLI;
                        else if (funct7 == 7'h20) op = SRAI;
                    end
                endcase
            end
            7'b0110011: begin
                case ({funct7, funct3})
                    {7'h00, 3'b000}: op = ADD;
                    {7'h20, 3'b000}: op = SUB;
                    {7'h00, 3'b001}: op = SLL;
                    {7'h00, 3'b010}: op = SLT;
                    {7'h00, 3'b011}: op = SLTU;
                    {7'h00, 3'b100}: op = XOR;
                    {7'h00, 3'b101}: op = SRL;
                    {7'h20, 3'b101}: op = SRA;
                    {7'h00, 3'b110}: op = OR;
                    {7'h00, 3'b111}: op = AND;
                    default:         op = NOP;
                endcase
            end
            default: op = NOP;
        endcase
    end

    // immediate by format
    always_comb begin
        case (opcode)
            7'b0100011: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            7'b1100011: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                               inst[11:8], 1'b0};
            7'b0110111,
            7'b0010111: imm = {inst[31:12], 12'h000};
            7'b1101111: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                               inst[30:21], 1'b0};
            default:    imm = {{20{inst[31]}}, inst[31:20]};
        endcase
    end

    always_comb begin
        o_dec.valid = i_fetch.valid;
        o_dec.op    = op;
        o_dec.rd    = inst[11:7];
        o_dec.a     = (o_rs1 == '0) ? '0 : i_rs1_data; // x0 reads zero
        o_dec.b     = (o_rs2 == '0) ? '0 : i_rs2_data;
        o_dec.imm   = imm;
        o_dec.pc    = i_fetch.pc;
    end

endmodule

// ==== execute_unit.sv ====
`timescale 1ns/1ns
`include "riscv_macros.svh"

module execute_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  riscv_pkg::dec_pkt_t  i_dec,
    output riscv_pkg::redirect_t o_redirect,
    output riscv_pkg::wb_t       o_wb,
    output riscv_pkg::uart_req_t o_uart
);
    import riscv_pkg::*;

    dec_pkt_t         ex;
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] addr_sum; // rs1 + imm, sb and jalr
    logic [`XLEN-1:0] target;
    logic             writes;
    logic             take;

    // decode/execute register
    always_ff @(posedge clk) begin
        ex <= i_dec;
        if (reset || o_redirect.taken) begin
            ex.valid <= 1'b0; // squash younger slot
        end
    end

    assign pc_plus4 = ex.pc + `XLEN'd4;
    assign addr_sum = ex.a + ex.imm;

    always_comb begin
        result = '0;
        writes = 1'b1;
        take   = 1'b0;
        target = ex.pc + ex.imm; // branch and jal
        case (ex.op)
            ADD:   result = ex.a + ex.b;
            SUB:   result = ex.a - ex.b;
            SLL:   result = ex.a << ex.b[4:0];
            SLT:   result = {{(`XLEN-1){1'b0}}, $signed(ex.a) < $signed(ex.b)};
            SLTU:  result = {{(`XLEN-1){1'b0}}, ex.a < ex.b};
            XOR:   result = ex.a ^ ex.b;
            SRL:   result = ex.a >> ex.b[4:0];
            SRA:   result = $signed(ex.a) >>> ex.b[4:0];
            OR:    result = ex.a | ex.b;
            AND:   result = ex.a & ex.b;
            ADDI:  result = addr_sum;
            SLTI:  result = {{(`XLEN-1){1'b0}}, $signed(ex.a) < $signed(ex.imm)};
            SLTIU: result = {{(`XLEN-1){1'b0}}, ex.a < ex.imm};
            XORI:  result = ex.a ^ ex.imm;
            ORI:   result = ex.a | ex.imm;
            ANDI:  result = ex.a & ex.imm;
            SLLI:  result = ex.a << ex.imm[4:0];
            SRLI:  result = ex.a >> ex.imm[4:0];
            SRAI:  result = $signed(ex.a) >>> ex.imm[4:0];
            LUI:   result = ex.imm;
            AUIPC: result = ex.pc + ex.imm;
            JAL: begin
                result = pc_plus4; // link
                take   = 1'b1;
            end
            JALR: begin
                result = pc_plus4;
                take   = 1'b1;
                target = {addr_sum[`XLEN-1:1], 1'b0};
            end
            BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                writes = 1'b0;
                case (ex.op)
                    BEQ:     take = (ex.a == ex.b);
                    BNE:     take = (ex.a != ex.b);
                    BLT:     take = ($signed(ex.a) < $signed(ex.b));
                    BGE:     take = ($signed(ex.a) >= $signed(ex.b));
                    BLTU:    take = (ex.a < ex.b);
                    default: take = (ex.a >= ex.b);
                endcase
            end
            default: writes = 1'b0; // sb, nop
        endcase
    end

    always_comb begin
        o_redirect.taken  = ex.valid && take;
        o_redirect.target = target;

        o_wb.wb_en = ex.valid && writes && (ex.rd != '0);
        o_wb.rd    = ex.rd;
        o_wb.data  = result;

        // only the uart address is mapped
        o_uart.en   = ex.valid && (ex.op == SB) && (addr_sum == `UART_TX_ADDR);
        o_uart.data = ex.b[7:0];
    end

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/1ns
`include "riscv_macros.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  riscv_pkg::redirect_t  i_redirect,
    input  logic [`XLEN-1:0]      i_inst,
    output logic [`XLEN-1:0]      o_pc,
    output riscv_pkg::fetch_pkt_t o_fetch
);
    import riscv_pkg::*;

    logic [`XLEN-1:0] pc;
    fetch_pkt_t       fetch_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (i_redirect.taken) begin
            pc <= i_redirect.target;
        end else begin
            pc <= pc + `XLEN'd4;
        end
    end

    // fetch/decode register
    always_ff @(posedge clk) begin
        fetch_q.pc <= pc;
        if (reset || i_redirect.taken) begin
            fetch_q.valid <= 1'b0;
            fetch_q.inst  <= `INST_NOP; // bubble
        end else begin
            fetch_q.valid <= 1'b1;
            fetch_q.inst  <= i_inst;
        end
    end

    assign o_pc    = pc;
    assign o_fetch = fetch_q;

endmodule

// ==== filelist.f ====
+incdir+.
riscv_pkg.sv
fetch_unit.sv
decode_unit.sv
reg_file.sv
execute_unit.sv
result_unit.sv
riscv_core.sv
riscv_assertions.sv
tb_checker.sv
tb_riscv.sv

// ==== reg_file.sv ====
`timescale 1ns/1ns
`include "riscv_macros.svh"

module reg_file (
    input  logic                   clk,
    input  logic [`REG_ADDR_W-1:0] i_rs1,
    input  logic [`REG_ADDR_W-1:0] i_rs2,
    output logic [`XLEN-1:0]       o_rs1_data,
    output logic [`XLEN-1:0]       o_rs2_data,
    input  riscv_pkg::wb_t         i_wb
);

    logic [`XLEN-1:0] regs [1:31]; // x0 not stored

    always_ff @(posedge clk) begin
        if (i_wb.wb_en && i_wb.rd != '0) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // same-cycle write wins over the stored value
    always_comb begin
        if (i_rs1 == '0) begin
            o_rs1_data = '0;
        end else if (i_wb.wb_en && i_wb.rd == i_rs1) begin
            o_rs1_data = i_wb.data;
        end else begin
            o_rs1_data = regs[i_rs1];
        end

        if (i_rs2 == '0) begin
            o_rs2_data = '0;
        end else if (i_wb.wb_en && i_wb.rd == i_rs2) begin
            o_rs2_data = i_wb.data;
        end else begin
            o_rs2_data = regs[i_rs2];
        end
    end

endmodule

// ==== result_unit.sv ====
`timescale 1ns/1ns

module result_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  riscv_pkg::wb_t       i_wb,
    input  riscv_pkg::uart_req_t i_uart,
    output riscv_pkg::wb_t       o_rf_wb,
    output logic                 o_uart_en,
    output logic [7:0]           o_uart_data
);

    // write-back lands in the same cycle as execute
    assign o_rf_wb = i_wb;

    always_ff @(posedge clk) begin
        if (reset) begin
            o_uart_en <= 1'b0;
        end else begin
            o_uart_en <= i_uart.en; // one cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (i_uart.en) begin
            o_uart_data <= i_uart.data; // held between sends
        end
    end

endmodule

// ==== riscv_assertions.sv ====
`timescale 1ns/1ns

module riscv_assertions (
    input logic                 clk,
    input logic                 reset,
    input riscv_pkg::dec_pkt_t  i_dec,
    input riscv_pkg::dec_pkt_t  i_ex,
    input riscv_pkg::redirect_t i_redirect
);

    int fail_count = 0;

    redirect_flush: assert property (@(posedge clk) disable iff (reset)
        i_redirect.taken |=> !i_ex.valid && !i_dec.valid) // both younger slots squashed
        else begin
            $error("taken redirect was followed by a valid younger packet");
            fail_count++;
        end

    pc_sequence: assert property (@(posedge clk) disable iff (reset)
        i_ex.valid && i_dec.valid |-> i_dec.pc == i_ex.pc + 32'd4)
        else begin
            $error("decode packet pc does not follow the execute packet pc");
            fail_count++;
        end

    target_aligned: assert property (@(posedge clk) disable iff (reset)
        i_redirect.taken |-> i_redirect.target[1:0] == 2'b00)
        else begin
            $error("taken redirect to a target that is not word aligned");
            fail_count++;
        end

endmodule

bind execute_unit riscv_assertions asrt0 (
    .clk        (clk),
    .reset      (reset),
    .i_dec      (i_dec),
    .i_ex       (ex),
    .i_redirect (o_redirect)
);

// ==== riscv_core.sv ====
`timescale 1ns/1ns
`include "riscv_macros.svh"

module riscv_core (
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] i_inst,
    output logic [`XLEN-1:0] o_pc,
    output logic             o_uart_en,
    output logic [7:0]       o_uart_data
);
    import riscv_pkg::*;

    redirect_t              redirect;
    fetch_pkt_t             fetch;
    dec_pkt_t               dec;
    wb_t                    ex_wb;
    wb_t                    rf_wb;
    uart_req_t              uart_req;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;

    fetch_unit fetch0 (
        .clk        (clk),
        .reset      (reset),
        .i_redirect (redirect),
        .i_inst     (i_inst),
        .o_pc       (o_pc),
        .o_fetch    (fetch)
    );

    decode_unit decode0 (
        .i_fetch    (fetch),
        .o_rs1      (rs1),
        .o_rs2      (rs2),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_dec      (dec)
    );

    reg_file rf0 (
        .clk        (clk),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_wb       (rf_wb)
    );

    execute_unit execute0 (
        .clk        (clk),
        .reset      (reset),
        .i_dec      (dec),
        .o_redirect (redirect),
        .o_wb       (ex_wb),
        .o_uart     (uart_req)
    );

    result_unit result0 (
        .clk         (clk),
        .reset       (reset),
        .i_wb        (ex_wb),
        .i_uart      (uart_req),
        .o_rf_wb     (rf_wb),
        .o_uart_en   (o_uart_en),
        .o_uart_data (o_uart_data)
    );

endmodule

// ==== riscv_macros.svh ====
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

`define XLEN 32
`define REG_ADDR_W 5

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

`define UART_TX_ADDR 32'h0002_0020 // sb here transmits one byte

// addi x0,x0,0
`define INST_NOP 32'h0000_0013

`endif

// ==== riscv_pkg.sv ====
`include "riscv_macros.svh"

package riscv_pkg;

    typedef enum logic [5:0] {
        NOP,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
        LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        SB
    } op_e;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic                   valid;
        op_e                    op;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       a;   // rs1 value
        logic [`XLEN-1:0]       b;   // rs2 value
        logic [`XLEN-1:0]       imm; // already sign extended
        logic [`XLEN-1:0]       pc;
    } dec_pkt_t;

    typedef struct packed {
        logic             taken;
        logic [`XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                   wb_en;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic       en;
        logic [7:0] data;
    } uart_req_t;

endpackage

// ==== run_sim.sh ====
#!/bin/bash
# build and run the riscv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module tb_riscv -f filelist.f -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_riscv" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// ==== tb_checker.sv ====
`timescale 1ns/1ns
`include "riscv_macros.svh"

module tb_checker #(
    parameter int PROG_LEN = 48
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] i_pc,
    input  logic [`XLEN-1:0] i_prog [0:PROG_LEN-1],
    input  logic             i_start,
    input  logic             i_finish,
    input  logic             i_uart_en,
    input  logic [7:0]       i_uart_data,
    output int               o_mismatches,
    output int               o_missing,
    output int               o_extra
);
    localparam logic [`XLEN-1:0] UART_ADDR = `UART_TX_ADDR;

    logic [7:0] expected [$];
    logic [7:0] want;
    int         prog_num;
    int         got_bytes;
    int         extra_bytes;

    // instruction-set model, collects the bytes stored to the uart port
    task automatic run_model();
        logic [31:0] x [0:31];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] iimm;
        logic [31:0] simm;
        logic [31:0] bimm;
        logic [31:0] jimm;
        logic [4:0]  sh;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        wr;
        logic        taken;
        int          k;
        int          steps;
        for (k = 0; k < 32; k++) x[k] = '0;
        pc    = `RESET_PC;
        steps = 0;
        while (steps < 4 * PROG_LEN) begin
            ins  = (pc < PROG_LEN * 4) ? i_prog[pc[7:2]] : `INST_NOP;
            f3   = ins[14:12];
            f7   = ins[31:25];
            sh   = ins[24:20];
            a    = x[ins[19:15]];
            b    = x[ins[24:20]];
            iimm = {{20{ins[31]}}, ins[31:20]};
            simm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            bimm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            jimm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            next_pc = pc + 32'd4;
            res   = '0;
            wr    = 1'b1;
            taken = 1'b0;
            case (ins[6:0])
                7'b0110111: res = {ins[31:12], 12'h000};
                7'b0010111: res = pc + {ins[31:12], 12'h000};
                7'b1101111: begin
                    res     = pc + 32'd4;
                    next_pc = pc + jimm;
                end
                7'b1100111: begin
                    wr = (f3 == 3'b000);
                    res = pc + 32'd4;
                    if (wr) next_pc = (a + iimm) & ~32'd1;
                end
                7'b1100011: begin
                    wr = 1'b0;
                    case (f3)
                        3'b000:  taken = (a == b);
                        3'b001:  taken = (a != b);
                        3'b100:  taken = ($signed(a) < $signed(b));
                        3'b101:  taken = ($signed(a) >= $signed(b));
                        3'b110:  taken = (a < b);
                        3'b111:  taken = (a >= b);
                        default: taken = 1'b0;
                    endcase
                    if (taken) next_pc = pc + bimm;
                end
                7'b0100011: begin
                    wr = 1'b0;
                    if (f3 == 3'b000 && a + simm == UART_ADDR) expected.push_back(b[7:0]);
                end
                7'b0010011: begin
                    case (f3)
                        3'b000:  res = a + iimm;
                        3'b010:  res = ($signed(a) < $signed(iimm)) ? 32'd1 : 32'd0;
                        3'b011:  res = (a < iimm) ? 32'd1 : 32'd0;
                        3'b100:  res = a ^ iimm;
                        3'b110:  res = a | iimm;
                        3'b111:  res = a & iimm;
                        3'b001:  begin
                            wr  = (f7 == 7'h00);
                            res = a << sh;
                        end
                        default: begin
                            wr = (f7 == 7'h00 || f7 == 7'h20);
                            if (f7 == 7'h20) begin
                                res = $signed(a) >>> sh; // srai
                            end else begin
                                res = a >> sh;
                            end
                        end
                    endcase
                end
                7'b0110011: begin
                    case ({f7, f3})
                        {7'h00, 3'b000}: res = a + b;
                        {7'h20, 3'b000}: res = a - b;
                        {7'h00, 3'b001}: res = a << b[4:0];
                        {7'h00, 3'b010}: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        {7'h00, 3'b011}: res = (a < b) ? 32'd1 : 32'd0;
                        {7'h00, 3'b100}: res = a ^ b;
                        {7'h00, 3'b101}: res = a >> b[4:0];
                        {7'h20, 3'b101}: res = $signed(a) >>> b[4:0];
                        {7'h00, 3'b110}: res = a | b;
                        {7'h00, 3'b111}: res = a & b;
                        default:         wr = 1'b0;
                    endcase
                end
                default: wr = 1'b0; // no-op
            endcase
            if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = res;
            if (next_pc == pc) break; // reached the jal-to-self
            pc = next_pc;
            steps++;
        end
    endtask

    always @(negedge clk) begin
        if (i_start) begin
            if (i_pc !== `RESET_PC) begin
                o_mismatches++;
                $display("CHECK FAILED t=%0t program %0d: pc %08h in reset, expected %08h",
                         $time, prog_num, i_pc, `RESET_PC);
            end
            expected.delete();
            got_bytes   = 0;
            extra_bytes = 0;
            run_model();
        end
        if (i_uart_en === 1'b1) begin
            if (reset || expected.size() == 0) begin
                extra_bytes++; // nothing was due
            end else begin
                want = expected.pop_front();
                got_bytes++;
                if (i_uart_data !== want) begin
                    o_mismatches++;
                    $display("CHECK FAILED t=%0t program %0d byte %0d: uart data %02h, expected %02h",
                             $time, prog_num, got_bytes, i_uart_data, want);
                end
            end
        end
        if (i_finish) begin
            if (expected.size() != 0) begin
                $display("program %0d: %0d expected uart byte(s) were never sent",
                         prog_num, expected.size());
                o_missing += expected.size();
            end
            if (extra_bytes != 0) begin
                $display("program %0d: the core sent %0d uart byte(s) that no store asked for",
                         prog_num, extra_bytes);
            end
            o_extra += extra_bytes;
            prog_num++;
        end
    end

endmodule

// ==== tb_riscv.sv ====
`timescale 1ns/1ns
`include "riscv_macros.svh"

module tb_riscv;
    localparam int CLK_PERIOD = 100;
    localparam int NUM_PROGS  = 8;
    localparam int PROG_LEN   = 48;
    localparam int TIMEOUT_NS = NUM_PROGS * (PROG_LEN + 40) * CLK_PERIOD * 2;
    localparam logic [`XLEN-1:0] UART_ADDR = `UART_TX_ADDR;
    localparam logic [`XLEN-1:0] LOOP_PC   = (PROG_LEN - 1) * 4;

    logic             clk;
    logic             reset;
    logic [`XLEN-1:0] inst;
    logic [`XLEN-1:0] pc;
    logic             uart_en;
    logic [7:0]       uart_data;
    logic             start;
    logic             finish;
    int               mismatches;
    int               missing;
    int               extra;
    int               assert_fails;
    int               p;
    logic [31:0]      rng;
    logic [31:0]      prog [0:PROG_LEN-1];

    riscv_core dut0 (
        .clk         (clk),
        .reset       (reset),
        .i_inst      (inst),
        .o_pc        (pc),
        .o_uart_en   (uart_en),
        .o_uart_data (uart_data)
    );

    tb_checker #(.PROG_LEN(PROG_LEN)) chk0 (
        .clk          (clk),
        .reset        (reset),
        .i_pc         (pc),
        .i_prog       (prog),
        .i_start      (start),
        .i_finish     (finish),
        .i_uart_en    (uart_en),
        .i_uart_data  (uart_data),
        .o_mismatches (mismatches),
        .o_missing    (missing),
        .o_extra      (extra)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] r_alu(input logic [31:0] s, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = s[2:0];
        f7 = (s[3] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00; // sub, sra
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_alu(input logic [31:0] s, input logic [11:0] imm_in,
                                          input logic [4:0] rd, input logic [4:0] rs1);
        logic [2:0]  f3;
        logic [11:0] imm;
        f3  = s[2:0];
        imm = imm_in;
        if (f3 == 3'b001 || f3 == 3'b101) begin
            imm = {1'b0, s[3] && (f3 == 3'b101), 5'd0, s[8:4]}; // bit 10 picks srai
        end
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    task automatic build_program();
        int          i;
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] hi;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  bf3;
        logic [11:0] simm;
        logic [12:0] off;
        logic [20:0] jimm;
        hi = UART_ADDR + 32'h800; // addi sign-extends the low part
        prog[0] = {hi[31:12], 5'd31, 7'b0110111};
        prog[1] = {UART_ADDR[11:0], 5'd31, 3'b000, 5'd31, 7'b0010011};
        for (i = 2; i < 9; i++) begin
            rng = xorshift32(rng);
            rd = 5'(i - 1);
            prog[i] = {rng[11:0], 5'd0, 3'b000, rd, 7'b0010011}; // seed x1..x7
        end
        for (i = 9; i < PROG_LEN - 1; i++) begin
            rng  = xorshift32(rng);
            r    = rng;
            rng  = xorshift32(rng);
            s    = rng;
            rd   = {2'b00, r[8:6]}; // x31 keeps the uart base
            rs1  = {2'b00, r[11:9]};
            rs2  = {2'b00, r[14:12]};
            off  = r[31] ? 13'd12 : 13'd8;
            jimm = {8'd0, off};
            bf3  = (s[2:1] == 2'b01) ? {2'b00, s[0]} : s[2:0];
            simm = (r[4:2] == 3'b000) ? 12'd4 : 12'd0; // offset 4 misses the port
            if (r[1:0] == 2'b00) begin
                prog[i] = {simm[11:5], rs2, 5'd31, 3'b000, simm[4:0], 7'b0100011};
            end else if (r[5:2] < 4'd3 && i <= PROG_LEN - 4) begin
                prog[i] = {off[12], off[10:5], rs2, rs1, bf3, off[4:1], off[11], 7'b1100011};
            end else if (r[5:2] == 4'd3 && i <= PROG_LEN - 4) begin
                prog[i] = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], rd, 7'b1101111};
            end else if (r[5:2] == 4'd4) begin
                prog[i] = {r[31:12], rd, 7'b0110111}; // lui
            end else if (r[5:2] == 4'd5) begin
                prog[i] = {r[31:12], rd, 7'b0010111}; // auipc
            end else if (r[5]) begin
                prog[i] = r_alu(s, rd, rs1, rs2);
            end else begin
                prog[i] = i_alu(s, r[26:15], rd, rs1);
            end
        end
        prog[PROG_LEN-1] = 32'h0000_006f; // jal x0, 0
    endtask

    task automatic run_program();
        int loops;
        loops = 0;
        @(negedge clk);
        reset <= 1'b1;
        start <= 1'b1;
        @(negedge clk);
        start <= 1'b0;
        @(negedge clk);
        reset <= 1'b0;
        // by the fourth visit the jal-to-self has executed
        while (loops < 4) begin
            @(negedge clk);
            if (pc == LOOP_PC) loops++;
        end
        finish <= 1'b1;
        @(negedge clk);
        finish <= 1'b0;
        @(negedge clk);
    endtask

    // instruction memory served from the program array
    always @(negedge clk) begin
        if (pc < PROG_LEN * 4) begin
            inst = prog[pc[7:2]];
        end else begin
            inst = `INST_NOP;
        end
    end

    initial begin
        rng    = 32'd36943;
        reset  = 1'b1;
        inst   = `INST_NOP;
        start  = 1'b0;
        finish = 1'b0;
        for (p = 0; p < NUM_PROGS; p++) begin
            build_program();
            run_program();
        end
        assert_fails = dut0.execute0.asrt0.fail_count;
        $display("errors: %0d mismatched, %0d missing, %0d extra, %0d assertion",
                 mismatches, missing, extra, assert_fails);
        if (mismatches + missing + extra + assert_fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the programs did not finish within %0d ns", TIMEOUT_NS);
        $display("Some tests failed");
        $finish;
    end

endmodule
